// ==== hw/vec_pkg.sv ====
`default_nettype none

package vec_pkg;

    ////////////////////
    // Geometry
    ////////////////////

    localparam int VLEN  = 64;
    localparam int VLENB = VLEN / 8;
    localparam int VREGS = 32;

    // Largest vl is VLENB elements of 8 bits times LMUL 8
    localparam int VL_W  = $clog2(VLENB * 8) + 1;

    typedef logic [VL_W-1:0] vl_t;

    ////////////////////
    // Encodings
    ////////////////////

    // Operation as classified by the core decoder
    typedef enum logic [3:0] {
        VOP_NONE,
        VOP_VSETVLI,
        VOP_VSETIVLI,
        VOP_VSETVL,
        VOP_ADD,
        VOP_SUB,
        VOP_RSUB,
        VOP_AND,
        VOP_OR,
        VOP_XOR
    } vec_op_e;

    // funct3 of OP-V, integer categories only
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPIVI = 3'b011,
        OPIVX = 3'b100
    } op_cat_e;

    typedef enum logic [2:0] {
        EW8  = 3'b000,
        EW16 = 3'b001,
        EW32 = 3'b010
    } vsew_e;

    typedef enum logic [2:0] {
        LMUL_1 = 3'b000,
        LMUL_2 = 3'b001,
        LMUL_4 = 3'b010,
        LMUL_8 = 3'b011
    } vlmul_e;

    ////////////////////
    // Bundles
    ////////////////////

    typedef struct packed {
        logic [31:0] instr;
        vec_op_e     op;
        logic [31:0] rs1_value;
        logic [31:0] rs2_value;
    } vec_issue_t;

    typedef struct packed {
        vl_t    vl;
        vsew_e  vsew;
        vlmul_e vlmul;
        logic   vta;
        logic   vma;
        logic   vill;
    } vec_cfg_t;

    // One byte-enabled register write
    typedef struct packed {
        logic [4:0]       addr;
        logic [VLEN-1:0]  data;
        logic [VLENB-1:0] be;
    } vec_write_t;

endpackage

`default_nettype wire

// ==== hw/vec_config.sv ====
`timescale 1ns/10ps
`default_nettype none

module vec_config (
    input  wire logic                clk,
    input  wire logic                reset,
    input  wire vec_pkg::vec_issue_t issue_i,
    input  wire logic                issue_valid_i,
    output vec_pkg::vec_cfg_t        cfg_o,
    output logic [31:0]              scalar_res_o,
    output logic                     scalar_valid_o
);

    logic [4:0]        rd_field;
    logic [4:0]        rs1_field;
    logic              is_vset;
    logic              is_vsetivli;
    logic [7:0]        vtype_raw;
    logic              vill_new;
    logic [31:0]       avl;
    vec_pkg::vl_t      vlmax;
    vec_pkg::vl_t      vl_new;
    vec_pkg::vec_cfg_t cfg_new;

    assign rd_field    = issue_i.instr[11:7];
    assign rs1_field   = issue_i.instr[19:15];
    assign is_vsetivli = (issue_i.op == vec_pkg::VOP_VSETIVLI);
    assign is_vset     = issue_valid_i && (issue_i.op inside
                         {vec_pkg::VOP_VSETVLI, vec_pkg::VOP_VSETIVLI, vec_pkg::VOP_VSETVL});

    ////////////////////
    // New vtype and vl
    ////////////////////

    always_comb begin
        // vtype from register for vsetvl, from zimm otherwise
        if (issue_i.op == vec_pkg::VOP_VSETVL) begin
            vtype_raw = issue_i.rs2_value[7:0];
        end else begin
            vtype_raw = issue_i.instr[27:20];
        end

        // Wider SEW and fractional LMUL are not supported
        vill_new = (vtype_raw[5:3] > 3'd2) || vtype_raw[2];

        cfg_new.vta  = vill_new ? 1'b0 : vtype_raw[6];
        cfg_new.vma  = vill_new ? 1'b0 : vtype_raw[7];
        cfg_new.vill = vill_new;
        cfg_new.vsew  = vill_new ? vec_pkg::EW8 : vec_pkg::vsew_e'(vtype_raw[5:3]);
        cfg_new.vlmul = vill_new ? vec_pkg::LMUL_1 : vec_pkg::vlmul_e'(vtype_raw[2:0]);

        // Elements per register, then times the group size
        vlmax = (vec_pkg::vl_t'(vec_pkg::VLENB) >> cfg_new.vsew) << cfg_new.vlmul;

        avl = is_vsetivli ? {27'b0, rs1_field} : issue_i.rs1_value;

        if (vill_new) begin
            vl_new = '0;
        end else if (!is_vsetivli && rs1_field == 5'd0 && rd_field != 5'd0) begin
            vl_new = vlmax;
        end else if (!is_vsetivli && rs1_field == 5'd0) begin
            vl_new = cfg_o.vl;
        end else if (avl > 32'(vlmax)) begin
            vl_new = vlmax;
        end else begin
            vl_new = vec_pkg::vl_t'(avl);
        end

        cfg_new.vl = vl_new;
    end

    ////////////////////
    // State
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            cfg_o          <= '{vl: '0, vsew: vec_pkg::EW8, vlmul: vec_pkg::LMUL_1,
                                vta: 1'b0, vma: 1'b0, vill: 1'b0};
            scalar_valid_o <= 1'b0;
        end else begin
            scalar_valid_o <= is_vset;
            if (is_vset) begin
                cfg_o <= cfg_new;
            end
        end
    end

    // New vl goes back to rd of the scalar core
    always_ff @(posedge clk) begin
        if (is_vset) begin
            scalar_res_o <= 32'(vl_new);
        end
    end

endmodule

`default_nettype wire

// ==== hw/vec_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module vec_regfile (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire logic [2:0][4:0]                rd_addr_i,
    output logic [2:0][vec_pkg::VLEN-1:0]       rd_data_o,
    input  wire logic [4:0]                     store_addr_i,
    output logic [vec_pkg::VLEN-1:0]            store_data_o,
    input  wire vec_pkg::vec_write_t            wr_i
);

    logic [vec_pkg::VLEN-1:0] regs [vec_pkg::VREGS];

    ////////////////////
    // Read ports
    ////////////////////

    // vs2, vs1 and old vd for the sequencer
    always_comb begin
        for (int p = 0; p < 3; p++) begin
            rd_data_o[p] = regs[rd_addr_i[p]];
        end
    end

    // Load-store unit view
    assign store_data_o = regs[store_addr_i];

    ////////////////////
    // Write port
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < vec_pkg::VREGS; r++) begin
                regs[r] <= '0;
            end
        end else if (wr_i.addr != 5'd0) begin
            // v0 holds the mask and stays untouched
            for (int j = 0; j < vec_pkg::VLENB; j++) begin
                if (wr_i.be[j]) begin
                    regs[wr_i.addr][8*j +: 8] <= wr_i.data[8*j +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== hw/vec_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module vec_alu (
    input  wire vec_pkg::vec_op_e          op_i,
    input  wire vec_pkg::vsew_e            vsew_i,
    input  wire logic [vec_pkg::VLEN-1:0]  a_i,
    input  wire logic [vec_pkg::VLEN-1:0]  b_i,
    output logic [vec_pkg::VLEN-1:0]       result_o
);

    logic                     is_sub;
    logic                     is_rsub;
    logic [vec_pkg::VLEN-1:0] add_x;
    logic [vec_pkg::VLEN-1:0] add_y;
    logic [vec_pkg::VLEN-1:0] sum;
    logic [8:0]               lane;
    logic                     carry;
    int                       elem_bytes;

    assign is_rsub = (op_i == vec_pkg::VOP_RSUB);
    assign is_sub  = (op_i == vec_pkg::VOP_SUB) || is_rsub;

    ////////////////////
    // Adder
    ////////////////////

    always_comb begin
        // Reverse subtract swaps minuend and subtrahend
        add_x = is_rsub ? b_i : a_i;
        add_y = is_rsub ? a_i : b_i;

        // Two's complement, the +1 enters as carry-in of each element
        if (is_sub) begin
            add_y = ~add_y;
        end

        elem_bytes = 1 << vsew_i;

        carry = 1'b0;
        for (int j = 0; j < vec_pkg::VLENB; j++) begin
            // First byte of an element restarts the carry chain
            if ((j % elem_bytes) == 0) begin
                carry = is_sub;
            end
            lane = {1'b0, add_x[8*j +: 8]} + {1'b0, add_y[8*j +: 8]} + {8'b0, carry};
            sum[8*j +: 8] = lane[7:0];
            carry = lane[8];
        end
    end

    ////////////////////
    // Result select
    ////////////////////

    always_comb begin
        case (op_i)
            vec_pkg::VOP_ADD,
            vec_pkg::VOP_SUB,
            vec_pkg::VOP_RSUB: begin
                result_o = sum;
            end
            vec_pkg::VOP_AND: begin
                result_o = a_i & b_i;
            end
            vec_pkg::VOP_OR: begin
                result_o = a_i | b_i;
            end
            vec_pkg::VOP_XOR: begin
                result_o = a_i ^ b_i;
            end
            default: begin
                // vset* and anything unknown
                result_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== hw/vec_sequencer.sv ====
`timescale 1ns/10ps
`default_nettype none

module vec_sequencer (
    input  wire logic                           clk,
    input  wire logic                           reset,
    input  wire vec_pkg::vec_issue_t            issue_i,
    input  wire logic                           issue_valid_i,
    input  wire vec_pkg::vec_cfg_t              cfg_i,
    output logic [2:0][4:0]                     rd_addr_o,
    input  wire logic [2:0][vec_pkg::VLEN-1:0]  rd_data_i,
    output vec_pkg::vec_op_e                    op_o,
    output vec_pkg::vsew_e                      vsew_o,
    output logic [vec_pkg::VLEN-1:0]            a_o,
    output logic [vec_pkg::VLEN-1:0]            b_o,
    input  wire logic [vec_pkg::VLEN-1:0]       result_i,
    output vec_pkg::vec_write_t                 wr_o,
    output logic                                busy_o
);

    typedef enum logic {
        S_IDLE,
        S_EXEC
    } state_e;

    state_e                    state;
    vec_pkg::vec_issue_t       issue_q;
    vec_pkg::vec_issue_t       cur;
    vec_pkg::op_cat_e          cat;
    logic [3:0]                k_q;
    logic [3:0]                read_k;
    logic [3:0]                group_len;
    logic                      start;
    logic                      read_en;
    logic [4:0]                vs1;
    logic [4:0]                vs2;
    logic [4:0]                vd;
    logic [vec_pkg::VLEN-1:0]  scalar_rep;
    logic [vec_pkg::VLEN-1:0]  imm_rep;
    logic [vec_pkg::VLENB-1:0] be_next;
    logic [vec_pkg::VLEN-1:0]  a_q;
    logic [vec_pkg::VLEN-1:0]  b_q;
    logic [vec_pkg::VLEN-1:0]  c_q;
    logic [4:0]                wd_q;
    logic [vec_pkg::VLENB-1:0] be_q;
    logic [vec_pkg::VLEN-1:0]  be_mask;

    ////////////////////
    // Decode
    ////////////////////

    // Issue port in the issue cycle, captured copy afterwards
    assign cur = (state == S_IDLE) ? issue_i : issue_q;

    assign vs2 = cur.instr[24:20];
    assign vs1 = cur.instr[19:15];
    assign vd  = cur.instr[11:7];
    assign cat = vec_pkg::op_cat_e'(cur.instr[14:12]);

    assign group_len = 4'd1 << cfg_i.vlmul;

    assign start = issue_valid_i && (state == S_IDLE) && !cfg_i.vill
                   && (cur.op inside {vec_pkg::VOP_ADD, vec_pkg::VOP_SUB, vec_pkg::VOP_RSUB,
                                      vec_pkg::VOP_AND, vec_pkg::VOP_OR, vec_pkg::VOP_XOR})
                   && (cat inside {vec_pkg::OPIVV, vec_pkg::OPIVI, vec_pkg::OPIVX});

    // Read stage walks member 0 in the issue cycle, then 1 .. L-1
    assign read_k  = (state == S_IDLE) ? 4'd0 : k_q;
    assign read_en = (state == S_IDLE) ? start : (k_q < group_len);

    assign rd_addr_o[0] = vs2 + {1'b0, read_k};
    assign rd_addr_o[1] = vs1 + {1'b0, read_k};
    assign rd_addr_o[2] = vd  + {1'b0, read_k};

    ////////////////////
    // Operand replication
    ////////////////////

    always_comb begin
        case (cfg_i.vsew)
            vec_pkg::EW8: begin
                scalar_rep = {(vec_pkg::VLENB){cur.rs1_value[7:0]}};
                imm_rep    = {(vec_pkg::VLENB){{3{vs1[4]}}, vs1}};
            end
            vec_pkg::EW16: begin
                scalar_rep = {(vec_pkg::VLENB/2){cur.rs1_value[15:0]}};
                imm_rep    = {(vec_pkg::VLENB/2){{11{vs1[4]}}, vs1}};
            end
            default: begin
                scalar_rep = {(vec_pkg::VLENB/4){cur.rs1_value}};
                imm_rep    = {(vec_pkg::VLENB/4){{27{vs1[4]}}, vs1}};
            end
        endcase
    end

    // Tail bytes stay undisturbed
    always_comb begin
        int idx;
        for (int j = 0; j < vec_pkg::VLENB; j++) begin
            idx = (int'(read_k) * vec_pkg::VLENB + j) >> cfg_i.vsew;
            be_next[j] = (idx < int'(cfg_i.vl));
        end
    end

    ////////////////////
    // FSM and pipeline
    ////////////////////

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= S_IDLE;
            k_q   <= 4'd0;
            be_q  <= '0;
        end else begin
            be_q <= read_en ? be_next : '0;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_EXEC;
                        k_q   <= 4'd1;
                    end
                end
                default: begin
                    // Last cycle drains the write stage
                    if (k_q == group_len) begin
                        state <= S_IDLE;
                    end else begin
                        k_q <= k_q + 4'd1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            issue_q <= issue_i;
        end
        a_q  <= rd_data_i[0];
        c_q  <= rd_data_i[2];
        wd_q <= rd_addr_o[2];
        case (cat)
            vec_pkg::OPIVX: b_q <= scalar_rep;
            vec_pkg::OPIVI: b_q <= imm_rep;
            default:        b_q <= rd_data_i[1];
        endcase
    end

    ////////////////////
    // Write stage
    ////////////////////

    always_comb begin
        for (int j = 0; j < vec_pkg::VLENB; j++) begin
            be_mask[8*j +: 8] = {8{be_q[j]}};
        end
    end

    assign op_o    = issue_q.op;
    assign vsew_o  = cfg_i.vsew;
    assign a_o     = a_q;
    assign b_o     = b_q;
    assign busy_o  = (state == S_EXEC);

    assign wr_o.addr = wd_q;
    assign wr_o.be   = be_q;
    assign wr_o.data = (result_i & be_mask) | (c_q & ~be_mask);

endmodule

`default_nettype wire

// ==== hw/vector_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module vector_unit (
    input  wire logic                      clk,
    input  wire logic                      reset,
    input  wire vec_pkg::vec_issue_t       issue_i,
    input  wire logic                      issue_valid_i,
    output logic                           busy_o,
    output logic [31:0]                    scalar_res_o,
    output logic                           scalar_valid_o,
    input  wire logic [4:0]                store_addr_i,
    output logic [vec_pkg::VLEN-1:0]       store_data_o
);

    vec_pkg::vec_cfg_t              cfg;
    vec_pkg::vec_op_e               alu_op;
    vec_pkg::vsew_e                 alu_vsew;
    vec_pkg::vec_write_t            wr;
    logic [2:0][4:0]                rd_addr;
    logic [2:0][vec_pkg::VLEN-1:0]  rd_data;
    logic [vec_pkg::VLEN-1:0]       alu_a;
    logic [vec_pkg::VLEN-1:0]       alu_b;
    logic [vec_pkg::VLEN-1:0]       alu_result;
    logic                           issue_accept;

    // Issues strobed while busy are dropped
    assign issue_accept = issue_valid_i && !busy_o;

    vec_config vec_config_i (
        .clk            (clk),
        .reset          (reset),
        .issue_i        (issue_i),
        .issue_valid_i  (issue_accept),
        .cfg_o          (cfg),
        .scalar_res_o   (scalar_res_o),
        .scalar_valid_o (scalar_valid_o)
    );

    vec_sequencer vec_sequencer_i (
        .clk           (clk),
        .reset         (reset),
        .issue_i       (issue_i),
        .issue_valid_i (issue_accept),
        .cfg_i         (cfg),
        .rd_addr_o     (rd_addr),
        .rd_data_i     (rd_data),
        .op_o          (alu_op),
        .vsew_o        (alu_vsew),
        .a_o           (alu_a),
        .b_o           (alu_b),
        .result_i      (alu_result),
        .wr_o          (wr),
        .busy_o        (busy_o)
    );

    vec_regfile vec_regfile_i (
        .clk          (clk),
        .reset        (reset),
        .rd_addr_i    (rd_addr),
        .rd_data_o    (rd_data),
        .store_addr_i (store_addr_i),
        .store_data_o (store_data_o),
        .wr_i         (wr)
    );

    vec_alu vec_alu_i (
        .op_i     (alu_op),
        .vsew_i   (alu_vsew),
        .a_i      (alu_a),
        .b_i      (alu_b),
        .result_o (alu_result)
    );

endmodule

`default_nettype wire

// ==== tests/vector_unit_assertions.sv ====
`timescale 1ns/10ps
`default_nettype none

module vector_unit_assertions (
    input wire logic              clk,
    input wire logic              reset,
    input wire logic              issue_valid_i,
    input wire logic              busy_o,
    input wire logic              scalar_valid_o,
    input wire vec_pkg::vec_cfg_t cfg_i
);

    int unsigned violations = 0;
    logic [4:0]  busy_run;
    logic [4:0]  group_len;

    // Configuration cannot change while busy, so the current LMUL is the one in use
    assign group_len = 5'd1 << cfg_i.vlmul;

    // Length of the current busy stretch
    always_ff @(posedge clk) begin
        if (reset || !busy_o) begin
            busy_run <= '0;
        end else begin
            busy_run <= busy_run + 5'd1;
        end
    end

    ////////////////////
    // Protocol rules
    ////////////////////

    idle_after_reset: assert property (@(posedge clk) reset |=> !busy_o && !scalar_valid_o)
        else begin
            $error("busy or scalar valid high right after reset");
            violations++;
        end

    scalar_valid_single: assert property (@(posedge clk) disable iff (reset)
        scalar_valid_o |=> !scalar_valid_o)
        else begin
            $error("scalar result valid held longer than one cycle");
            violations++;
        end

    no_issue_when_busy: assert property (@(posedge clk) disable iff (reset)
        !(issue_valid_i && busy_o))
        else begin
            $error("instruction issued while the unit was busy");
            violations++;
        end

    busy_group_length: assert property (@(posedge clk) disable iff (reset)
        $fell(busy_o) |-> busy_run == group_len)
        else begin
            $error("busy ran %0d cycles for a group of %0d", busy_run, group_len);
            violations++;
        end

endmodule

bind vector_unit vector_unit_assertions assertions_i (
    .clk            (clk),
    .reset          (reset),
    .issue_valid_i  (issue_valid_i),
    .busy_o         (busy_o),
    .scalar_valid_o (scalar_valid_o),
    .cfg_i          (cfg)
);

`default_nettype wire

// ==== tests/vector_unit_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module vector_unit_tb;

    // Reset, one register sweep and about 120 issues of up to 18 cycles, with margin
    localparam int MAX_CYCLES   = 3000;
    localparam int RESET_CYCLES = 16;

    logic                     clk = 1'b0;
    logic                     reset;
    vec_pkg::vec_issue_t      issue;
    logic                     issue_valid;
    logic                     busy;
    logic [31:0]              scalar_res;
    logic                     scalar_valid;
    logic [4:0]               store_addr;
    logic [vec_pkg::VLEN-1:0] store_data;

    // Reference model state
    logic [vec_pkg::VLEN-1:0] ref_regs [vec_pkg::VREGS];
    int                       ref_vl;
    int                       ref_sew;
    int                       ref_lmul;

    logic [31:0] lfsr   = 32'h61ada8c1;
    int          cycles = 0;
    int          checks = 0;
    int          errors = 0;

    vector_unit vector_unit_i (
        .clk            (clk),
        .reset          (reset),
        .issue_i        (issue),
        .issue_valid_i  (issue_valid),
        .busy_o         (busy),
        .scalar_res_o   (scalar_res),
        .scalar_valid_o (scalar_valid),
        .store_addr_i   (store_addr),
        .store_data_o   (store_data)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    end

    ////////////////////
    // Helpers
    ////////////////////

    // Galois LFSR, one step per bit
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] bits;
        logic        out;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            out  = lfsr[0];
            lfsr = lfsr >> 1;
            if (out) begin
                lfsr = lfsr ^ 32'h8020_0003;
            end
            bits = {bits[30:0], out};
        end
        return bits;
    endfunction

    task automatic compare_word(input string name, input logic [63:0] exp,
                                input logic [63:0] act);
        checks++;
        assert (act === exp) else begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input int r);
        @(posedge clk);
        #1;
        store_addr = 5'(r);
        @(negedge clk);
        compare_word($sformatf("%s v%0d", name, r), ref_regs[r], store_data);
    endtask

    task automatic issue_instr(input logic [31:0] instr, input vec_pkg::vec_op_e op,
                               input logic [31:0] rs1v, input logic [31:0] rs2v);
        @(posedge clk);
        #1;
        issue       = '{instr: instr, op: op, rs1_value: rs1v, rs2_value: rs2v};
        issue_valid = 1'b1;
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
    endtask

    ////////////////////
    // Reference model
    ////////////////////

    function automatic int predict_vl(input vec_pkg::vec_op_e kind, input logic [4:0] rd,
                                      input logic [4:0] rs1, input logic [31:0] avl,
                                      input int sew, input int lmul);
        int          vlmax;
        logic [31:0] req;
        vlmax = (vec_pkg::VLENB >> sew) << lmul;
        if (kind == vec_pkg::VOP_VSETIVLI) begin
            req = {27'b0, rs1};
        end else if (rs1 == 5'd0 && rd != 5'd0) begin
            req = 32'(vlmax);
        end else if (rs1 == 5'd0) begin
            return ref_vl;
        end else begin
            req = avl;
        end
        return (req > 32'(vlmax)) ? vlmax : int'(req);
    endfunction

    // Per-element modular arithmetic, tail and v0 left alone
    function automatic void predict_op(input vec_pkg::vec_op_e op, input vec_pkg::op_cat_e cat,
                                       input logic [4:0] vd, input logic [4:0] vs2,
                                       input logic [4:0] src, input logic [31:0] scalar);
        logic [vec_pkg::VLEN-1:0] snap [vec_pkg::VREGS];
        logic [63:0]              mask;
        logic [63:0]              a;
        logic [63:0]              b;
        logic [63:0]              r;
        int                       w;
        int                       per_reg;
        int                       d;
        snap    = ref_regs;
        w       = 8 << ref_sew;
        per_reg = vec_pkg::VLENB >> ref_sew;
        mask    = (64'd1 << w) - 64'd1;
        for (int k = 0; k < (1 << ref_lmul); k++) begin
            d = (vd + k) % vec_pkg::VREGS;
            for (int e = 0; e < per_reg; e++) begin
                if (k * per_reg + e < ref_vl && d != 0) begin
                    a = (snap[(vs2 + k) % vec_pkg::VREGS] >> (e * w)) & mask;
                    case (cat)
                        vec_pkg::OPIVV: b = (snap[(src + k) % vec_pkg::VREGS] >> (e * w)) & mask;
                        vec_pkg::OPIVX: b = 64'(scalar) & mask;
                        default:        b = {{59{src[4]}}, src} & mask;
                    endcase
                    case (op)
                        vec_pkg::VOP_ADD:  r = a + b;
                        vec_pkg::VOP_SUB:  r = a - b;
                        vec_pkg::VOP_RSUB: r = b - a;
                        vec_pkg::VOP_AND:  r = a & b;
                        vec_pkg::VOP_OR:   r = a | b;
                        default:           r = a ^ b;
                    endcase
                    ref_regs[d] = (ref_regs[d] & ~(mask << (e * w))) | ((r & mask) << (e * w));
                end
            end
        end
    endfunction

    ////////////////////
    // Instruction runners
    ////////////////////

    task automatic configure(input vec_pkg::vec_op_e kind, input logic [4:0] rd,
                             input logic [4:0] rs1, input logic [31:0] avl,
                             input int sew, input int lmul);
        logic [7:0]  vtype;
        logic [31:0] instr;
        int          vl_exp;
        vtype = {2'b00, 3'(sew), 3'(lmul)};
        case (kind)
            vec_pkg::VOP_VSETIVLI: instr = {4'b1100, vtype, rs1, 3'b111, rd, 7'h57};
            vec_pkg::VOP_VSETVL:   instr = {7'b1000000, 5'd4, rs1, 3'b111, rd, 7'h57};
            default:               instr = {4'b0000, vtype, rs1, 3'b111, rd, 7'h57};
        endcase
        vl_exp = predict_vl(kind, rd, rs1, avl, sew, lmul);
        issue_instr(instr, kind, avl, {24'b0, vtype});
        @(negedge clk);
        compare_word("config valid", 64'd1, 64'(scalar_valid));
        compare_word($sformatf("config vl e%0d m%0d", 8 << sew, 1 << lmul),
                     64'(vl_exp), 64'(scalar_res));
        ref_vl   = vl_exp;
        ref_sew  = sew;
        ref_lmul = lmul;
    endtask

    task automatic execute_op(input string name, input vec_pkg::vec_op_e op,
                              input vec_pkg::op_cat_e cat, input logic [4:0] vd,
                              input logic [4:0] vs2, input logic [4:0] src,
                              input logic [31:0] scalar);
        logic [5:0]  funct6;
        logic [31:0] instr;
        case (op)
            vec_pkg::VOP_SUB:  funct6 = 6'b000010;
            vec_pkg::VOP_RSUB: funct6 = 6'b000011;
            vec_pkg::VOP_AND:  funct6 = 6'b001001;
            vec_pkg::VOP_OR:   funct6 = 6'b001010;
            vec_pkg::VOP_XOR:  funct6 = 6'b001011;
            default:           funct6 = 6'b000000;
        endcase
        instr = {funct6, 1'b1, vs2, src, 3'(cat), vd, 7'h57};
        predict_op(op, cat, vd, vs2, src, scalar);
        issue_instr(instr, op, scalar, 32'd0);
        while (busy) begin
            @(posedge clk);
            #1;
        end
        for (int k = 0; k < (1 << ref_lmul); k++) begin
            check_reg(name, (vd + k) % vec_pkg::VREGS);
        end
    endtask

    ////////////////////
    // Test sequence
    ////////////////////

    initial begin
        reset       = 1'b1;
        issue       = '0;
        issue_valid = 1'b0;
        store_addr  = '0;
        ref_vl      = 0;
        ref_sew     = 0;
        ref_lmul    = 0;
        for (int r = 0; r < vec_pkg::VREGS; r++) begin
            ref_regs[r] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        // Register file comes out of reset cleared
        for (int r = 0; r < vec_pkg::VREGS; r++) begin
            check_reg("reset", r);
        end

        // Fill both words of v1..v31 with different random values
        configure(vec_pkg::VOP_VSETVLI, 5'd1, 5'd1, 32'd2, 2, 0);
        for (int r = 1; r < vec_pkg::VREGS; r++) begin
            execute_op("preload", vec_pkg::VOP_XOR, vec_pkg::OPIVX, 5'(r), 5'd0, 5'd1,
                       lfsr_bits(32));
        end
        configure(vec_pkg::VOP_VSETVLI, 5'd1, 5'd1, 32'd1, 2, 0);
        for (int r = 1; r < vec_pkg::VREGS; r++) begin
            execute_op("preload", vec_pkg::VOP_XOR, vec_pkg::OPIVX, 5'(r), 5'd0, 5'd1,
                       lfsr_bits(32));
        end

        // vl rules for each vset form
        configure(vec_pkg::VOP_VSETVLI, 5'd1, 5'd0, 32'd0, 1, 1);
        configure(vec_pkg::VOP_VSETVLI, 5'd0, 5'd0, 32'd0, 2, 0);
        configure(vec_pkg::VOP_VSETVLI, 5'd2, 5'd3, 32'd100, 0, 2);
        configure(vec_pkg::VOP_VSETVLI, 5'd2, 5'd3, 32'd5, 0, 2);
        configure(vec_pkg::VOP_VSETIVLI, 5'd4, 5'd7, 32'd0, 1, 0);
        configure(vec_pkg::VOP_VSETIVLI, 5'd4, 5'd3, 32'd0, 0, 3);
        configure(vec_pkg::VOP_VSETVL, 5'd1, 5'd2, 32'd20, 0, 1);
        configure(vec_pkg::VOP_VSETVL, 5'd3, 5'd0, 32'd0, 2, 3);

        // Vector-vector arithmetic at each element width
        for (int s = 0; s < 3; s++) begin
            configure(vec_pkg::VOP_VSETVLI, 5'd1, 5'd0, 32'd0, s, 0);
            execute_op($sformatf("vadd.vv e%0d", 8 << s), vec_pkg::VOP_ADD,
                       vec_pkg::OPIVV, 5'd20, 5'd1, 5'd2, 32'd0);
            execute_op($sformatf("vsub.vv e%0d", 8 << s), vec_pkg::VOP_SUB,
                       vec_pkg::OPIVV, 5'd21, 5'd3, 5'd4, 32'd0);
            execute_op($sformatf("vrsub.vv e%0d", 8 << s), vec_pkg::VOP_RSUB,
                       vec_pkg::OPIVV, 5'd22, 5'd5, 5'd6, 32'd0);
        end

        // Logic ops with replicated scalar and immediate
        for (int s = 0; s < 3; s++) begin
            configure(vec_pkg::VOP_VSETVLI, 5'd1, 5'd0, 32'd0, s, 0);
            execute_op($sformatf("vand.vx e%0d", 8 << s), vec_pkg::VOP_AND,
                       vec_pkg::OPIVX, 5'd23, 5'd7, 5'd10, lfsr_bits(32));
            execute_op($sformatf("vor.vx e%0d", 8 << s), vec_pkg::VOP_OR,
                       vec_pkg::OPIVX, 5'd24, 5'd8, 5'd10, lfsr_bits(32));
            execute_op($sformatf("vxor.vx e%0d", 8 << s), vec_pkg::VOP_XOR,
                       vec_pkg::OPIVX, 5'd25, 5'd9, 5'd10, lfsr_bits(32));
            execute_op($sformatf("vand.vi e%0d", 8 << s), vec_pkg::VOP_AND,
                       vec_pkg::OPIVI, 5'd26, 5'd11, 5'(lfsr_bits(5)), 32'd0);
            execute_op($sformatf("vor.vi e%0d", 8 << s), vec_pkg::VOP_OR,
                       vec_pkg::OPIVI, 5'd27, 5'd12, 5'(lfsr_bits(5)), 32'd0);
            execute_op($sformatf("vxor.vi e%0d", 8 << s), vec_pkg::VOP_XOR,
                       vec_pkg::OPIVI, 5'd28, 5'd13, 5'(lfsr_bits(5)), 32'd0);
        end

        // Register groups with vl below vlmax
        configure(vec_pkg::VOP_VSETVLI, 5'd1, 5'd5, 32'd11, 0, 1);
        execute_op("group m2 vadd", vec_pkg::VOP_ADD, vec_pkg::OPIVV,
                   5'd14, 5'd16, 5'd18, 32'd0);
        execute_op("group m2 vxor.vi", vec_pkg::VOP_XOR, vec_pkg::OPIVI,
                   5'd30, 5'd20, 5'(lfsr_bits(5)), 32'd0);
        configure(vec_pkg::VOP_VSETIVLI, 5'd1, 5'd13, 32'd0, 1, 2);
        execute_op("group m4 vadd", vec_pkg::VOP_ADD, vec_pkg::OPIVV,
                   5'd12, 5'd16, 5'd20, 32'd0);
        execute_op("group m4 vsub.vx", vec_pkg::VOP_SUB, vec_pkg::OPIVX,
                   5'd24, 5'd4, 5'd10, lfsr_bits(32));
        configure(vec_pkg::VOP_VSETVL, 5'd1, 5'd5, 32'd9, 2, 3);
        execute_op("group m8 vadd", vec_pkg::VOP_ADD, vec_pkg::OPIVV,
                   5'd8, 5'd16, 5'd24, 32'd0);
        execute_op("group m8 vrsub.vi", vec_pkg::VOP_RSUB, vec_pkg::OPIVI,
                   5'd24, 5'd16, 5'(lfsr_bits(5)), 32'd0);

        // v0 is the mask register and never written
        configure(vec_pkg::VOP_VSETVLI, 5'd1, 5'd0, 32'd0, 0, 0);
        execute_op("v0 write", vec_pkg::VOP_ADD, vec_pkg::OPIVV, 5'd0, 5'd1, 5'd2, 32'd0);

        $display("Checks: %0d, mismatches: %0d, assertion failures: %0d", checks, errors,
                 vector_unit_i.assertions_i.violations);
        if (errors == 0 && vector_unit_i.assertions_i.violations == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
hw/vec_pkg.sv
hw/vec_config.sv
hw/vec_regfile.sv
hw/vec_alu.sv
hw/vec_sequencer.sv
hw/vector_unit.sv
tests/vector_unit_assertions.sv
tests/vector_unit_tb.sv
